//--- all.f
src/dds_lab_pkg.sv
src/key_command_decoder.sv
src/lfsr_ticker.sv
src/dds_modulator.sv
src/scope_sampler.sv
src/dds_lab_top.sv
test/tb_clock_gen.sv
test/tb_dds_lab.sv

//--- run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it and check the log
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module tb_dds_lab -f all.f -o tb_dds_lab_sim
./obj_dir/tb_dds_lab_sim > sim.log 2>&1 || true
cat sim.log
if grep -q "^RESULT: PASS$" sim.log; then
   echo "simulation passed"
else
   echo "simulation failed"
   exit 1
fi

//--- src/dds_lab_pkg.sv
package dds_lab_pkg;

   ////////////////////
   // widths
   ////////////////////
   localparam int PHASE_W  = 32;   // phase accumulator
   localparam int SAMPLE_W = 12;   // signed waveform sample
   localparam int LFSR_W   = 5;
   localparam int GRAPH_W  = 8;    // scope trace sample
   localparam int HELD_W   = 10;   // held-key flags

   ////////////////////
   // keyboard event codes
   ////////////////////
   // a break code is its make code with bit 7 set
   typedef enum logic [7:0] {
      SC_MAKE_1     = 8'h02,
      SC_MAKE_2     = 8'h03,
      SC_MAKE_3     = 8'h04,
      SC_MAKE_4     = 8'h05,
      SC_MAKE_5     = 8'h06,
      SC_MAKE_6     = 8'h07,
      SC_MAKE_7     = 8'h08,
      SC_MAKE_8     = 8'h09,
      SC_MAKE_UP    = 8'h48,
      SC_MAKE_DOWN  = 8'h50,
      SC_BREAK_1    = 8'h82,
      SC_BREAK_2    = 8'h83,
      SC_BREAK_3    = 8'h84,
      SC_BREAK_4    = 8'h85,
      SC_BREAK_5    = 8'h86,
      SC_BREAK_6    = 8'h87,
      SC_BREAK_7    = 8'h88,
      SC_BREAK_8    = 8'h89,
      SC_BREAK_UP   = 8'hc8,
      SC_BREAK_DOWN = 8'hd0
   } scan_event_e;

   // bit positions in the held-key vector
   typedef enum logic [3:0] {
      HELD_KEY1 = 4'd0,
      HELD_KEY2 = 4'd1,
      HELD_KEY3 = 4'd2,
      HELD_KEY4 = 4'd3,
      HELD_KEY5 = 4'd4,
      HELD_KEY6 = 4'd5,
      HELD_KEY7 = 4'd6,
      HELD_KEY8 = 4'd7,
      HELD_UP   = 4'd8,
      HELD_DOWN = 4'd9
   } held_idx_e;

   typedef enum logic [1:0] {
      WAVE_SQUARE   = 2'd0,   // key 1
      WAVE_SAW      = 2'd1,   // key 2
      WAVE_TRIANGLE = 2'd2,   // key 3
      WAVE_NOISE    = 2'd3    // key 4
   } waveform_e;

   typedef enum logic [1:0] {
      MOD_NONE = 2'd0,   // key 5
      MOD_ASK  = 2'd1,   // key 6
      MOD_FSK  = 2'd2,   // key 7
      MOD_BPSK = 2'd3    // key 8
   } modulation_e;

endpackage

//--- src/dds_lab_top.sv
`timescale 1ns/1ps

module dds_lab_top #(
   parameter int                              TICK_DIVIDE   = 25_000_000,
   parameter int                              SAMPLE_DIVIDE = 70_000,
   parameter logic [dds_lab_pkg::PHASE_W-1:0] BASE_INC      = 32'd4194304,
   parameter logic [dds_lab_pkg::PHASE_W-1:0] FREQ_STEP     = 32'd1048576
) (
   input  logic                                    CLK_25MHZ,
   input  logic                                    reset_from_key,
   input  logic                                    key_event_ready,
   input  dds_lab_pkg::scan_event_e                key_event_type,
   output logic [dds_lab_pkg::HELD_W-1:0]          held_keys,   // LED levels
   output dds_lab_pkg::waveform_e                  wave_sel,
   output dds_lab_pkg::modulation_e                mod_sel,
   output logic [dds_lab_pkg::PHASE_W-1:0]         freq_inc,
   output logic [dds_lab_pkg::LFSR_W-1:0]          lfsr_state,
   output logic                                    lfsr_tick,
   output logic signed [dds_lab_pkg::SAMPLE_W-1:0] signal_sample,
   output logic signed [dds_lab_pkg::SAMPLE_W-1:0] mod_sample,
   output logic                                    graph_valid,
   output logic [dds_lab_pkg::GRAPH_W-1:0]         graph_data
);

   key_command_decoder #(
      .BASE_INC        (BASE_INC),
      .FREQ_STEP       (FREQ_STEP)
   ) key_command_decoder_inst (
      .CLK_25MHZ       (CLK_25MHZ),
      .reset_from_key  (reset_from_key),
      .key_event_ready (key_event_ready),
      .key_event_type  (key_event_type),
      .held_keys       (held_keys),
      .wave_sel        (wave_sel),
      .mod_sel         (mod_sel),
      .freq_inc        (freq_inc)
   );

   lfsr_ticker #(
      .TICK_DIVIDE     (TICK_DIVIDE)
   ) lfsr_ticker_inst (
      .CLK_25MHZ       (CLK_25MHZ),
      .reset_from_key  (reset_from_key),
      .lfsr_tick       (lfsr_tick),
      .lfsr_state      (lfsr_state)
   );

   dds_modulator dds_modulator_inst (
      .CLK_25MHZ       (CLK_25MHZ),
      .reset_from_key  (reset_from_key),
      .wave_sel        (wave_sel),
      .mod_sel         (mod_sel),
      .freq_inc        (freq_inc),
      .lfsr_bit        (lfsr_state[0]),   // keying bit
      .lfsr_state      (lfsr_state),
      .signal_sample   (signal_sample),
      .mod_sample      (mod_sample)
   );

   scope_sampler #(
      .SAMPLE_DIVIDE   (SAMPLE_DIVIDE)
   ) scope_sampler_inst (
      .CLK_25MHZ       (CLK_25MHZ),
      .reset_from_key  (reset_from_key),
      .mod_sample      (mod_sample),
      .graph_valid     (graph_valid),
      .graph_data      (graph_data)
   );

endmodule

//--- src/dds_modulator.sv
`timescale 1ns/1ps

module dds_modulator (
   input  logic                                   CLK_25MHZ,
   input  logic                                   reset_from_key,
   input  dds_lab_pkg::waveform_e                 wave_sel,
   input  dds_lab_pkg::modulation_e               mod_sel,
   input  logic [dds_lab_pkg::PHASE_W-1:0]        freq_inc,
   input  logic                                   lfsr_bit,
   input  logic [dds_lab_pkg::LFSR_W-1:0]         lfsr_state,
   output logic signed [dds_lab_pkg::SAMPLE_W-1:0] signal_sample,
   output logic signed [dds_lab_pkg::SAMPLE_W-1:0] mod_sample
);

   localparam int SW = dds_lab_pkg::SAMPLE_W;
   localparam int PW = dds_lab_pkg::PHASE_W;
   localparam logic signed [SW-1:0] FULL_POS = 12'sd2047;
   localparam logic signed [SW-1:0] FULL_NEG = -12'sd2047;

   logic [PW-1:0]            phase_acc;
   logic [PW-1:0]            phase_step;   // increment after FSK
   logic [SW-1:0]            p;            // top bits of the phase
   logic [SW-1:0]            tri_ramp;
   logic signed [SW-1:0]     wave_next;

   ////////////////////
   // phase accumulator
   ////////////////////
   always_comb
   begin
      if (mod_sel == dds_lab_pkg::MOD_FSK && lfsr_bit)
         phase_step = {freq_inc[PW-2:0], 1'b0};   // mark tone at twice the rate
      else
         phase_step = freq_inc;
   end

   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
         phase_acc <= '0;
      else
         phase_acc <= phase_acc + phase_step;   // wraps freely
   end

   assign p = phase_acc[PW-1 -: SW];

   ////////////////////
   // waveform shaping
   ////////////////////
   // up on the first half of the cycle, down on the second
   assign tri_ramp = p[SW-1] ? ~{p[SW-2:0], 1'b0} : {p[SW-2:0], 1'b0};

   always_comb
   begin
      case (wave_sel)
         dds_lab_pkg::WAVE_SQUARE:
            wave_next = p[SW-1] ? FULL_NEG : FULL_POS;
         dds_lab_pkg::WAVE_SAW:
            wave_next = {~p[SW-1], p[SW-2:0]};   // offset binary to signed
         dds_lab_pkg::WAVE_TRIANGLE:
            wave_next = {~tri_ramp[SW-1], tri_ramp[SW-2:0]};
         dds_lab_pkg::WAVE_NOISE:
            wave_next = {lfsr_state, {(SW - dds_lab_pkg::LFSR_W){1'b0}}};
         default:
            wave_next = '0;
      endcase
   end

   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
         signal_sample <= '0;
      else
         signal_sample <= wave_next;
   end

   ////////////////////
   // modulation
   ////////////////////
   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         mod_sample <= '0;
      end
      else
      begin
         case (mod_sel)
            dds_lab_pkg::MOD_ASK:
               mod_sample <= lfsr_bit ? signal_sample : '0;   // on-off keying
            dds_lab_pkg::MOD_BPSK:
               mod_sample <= lfsr_bit ? -signal_sample : signal_sample;
            dds_lab_pkg::MOD_FSK,
            dds_lab_pkg::MOD_NONE:
               mod_sample <= signal_sample;   // FSK acts on the phase
            default:
               mod_sample <= signal_sample;
         endcase
      end
   end

   // ASK space must silence the output on the next sample
   a_ask_space: assert property (@(posedge CLK_25MHZ) disable iff (reset_from_key)
      (mod_sel == dds_lab_pkg::MOD_ASK && !lfsr_bit) |=> (mod_sample == '0));

endmodule

//--- src/key_command_decoder.sv
`timescale 1ns/1ps

module key_command_decoder #(
   parameter logic [dds_lab_pkg::PHASE_W-1:0] BASE_INC  = 32'd4194304,
   parameter logic [dds_lab_pkg::PHASE_W-1:0] FREQ_STEP = 32'd1048576
) (
   input  logic                               CLK_25MHZ,
   input  logic                               reset_from_key,
   input  logic                               key_event_ready,
   input  dds_lab_pkg::scan_event_e           key_event_type,
   output logic [dds_lab_pkg::HELD_W-1:0]     held_keys,
   output dds_lab_pkg::waveform_e             wave_sel,
   output dds_lab_pkg::modulation_e           mod_sel,
   output logic [dds_lab_pkg::PHASE_W-1:0]    freq_inc
);

   localparam logic [dds_lab_pkg::PHASE_W-1:0] INC_MAX = '1;

   logic [7:0] make_code;   // event with the break bit stripped
   logic       ev_make;
   logic       ev_hit;      // one of the known keys
   logic [3:0] ev_pos;      // held-key bit position

   ////////////////////
   // event decode
   ////////////////////
   always_comb
   begin
      make_code = key_event_type & 8'h7f;
      ev_make   = ~key_event_type[7];
      ev_hit    = 1'b1;
      case (make_code)
         dds_lab_pkg::SC_MAKE_1:    ev_pos = dds_lab_pkg::HELD_KEY1;
         dds_lab_pkg::SC_MAKE_2:    ev_pos = dds_lab_pkg::HELD_KEY2;
         dds_lab_pkg::SC_MAKE_3:    ev_pos = dds_lab_pkg::HELD_KEY3;
         dds_lab_pkg::SC_MAKE_4:    ev_pos = dds_lab_pkg::HELD_KEY4;
         dds_lab_pkg::SC_MAKE_5:    ev_pos = dds_lab_pkg::HELD_KEY5;
         dds_lab_pkg::SC_MAKE_6:    ev_pos = dds_lab_pkg::HELD_KEY6;
         dds_lab_pkg::SC_MAKE_7:    ev_pos = dds_lab_pkg::HELD_KEY7;
         dds_lab_pkg::SC_MAKE_8:    ev_pos = dds_lab_pkg::HELD_KEY8;
         dds_lab_pkg::SC_MAKE_UP:   ev_pos = dds_lab_pkg::HELD_UP;
         dds_lab_pkg::SC_MAKE_DOWN: ev_pos = dds_lab_pkg::HELD_DOWN;
         default:
         begin
            ev_pos = dds_lab_pkg::HELD_KEY1;
            ev_hit = 1'b0;   // unknown code, ignored
         end
      endcase
   end

   ////////////////////
   // held flags and selections
   ////////////////////
   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         held_keys <= '0;
         wave_sel  <= dds_lab_pkg::WAVE_SQUARE;
         mod_sel   <= dds_lab_pkg::MOD_NONE;
         freq_inc  <= BASE_INC;
      end
      else if (key_event_ready && ev_hit)
      begin
         held_keys[ev_pos] <= ev_make;   // make sets, break clears
         if (ev_make)
         begin
            case (ev_pos)
               dds_lab_pkg::HELD_UP:
               begin
                  if (freq_inc > INC_MAX - FREQ_STEP)
                     freq_inc <= INC_MAX;   // clamp at the top
                  else
                     freq_inc <= freq_inc + FREQ_STEP;
               end
               dds_lab_pkg::HELD_DOWN:
               begin
                  if (freq_inc - FREQ_STEP < FREQ_STEP)
                     freq_inc <= FREQ_STEP;   // floor is one step
                  else
                     freq_inc <= freq_inc - FREQ_STEP;
               end
               default:
               begin
                  if (ev_pos < 4'(dds_lab_pkg::HELD_KEY5))
                     wave_sel <= dds_lab_pkg::waveform_e'(ev_pos[1:0]);
                  else
                     mod_sel <= dds_lab_pkg::modulation_e'(ev_pos[1:0]);
               end
            endcase
         end
      end
   end

   // stepping down from any reachable value must stop at the floor
   a_freq_floor: assert property (@(posedge CLK_25MHZ) disable iff (reset_from_key)
      freq_inc >= FREQ_STEP);

endmodule

//--- src/lfsr_ticker.sv
`timescale 1ns/1ps

module lfsr_ticker #(
   parameter int TICK_DIVIDE = 25_000_000
) (
   input  logic                            CLK_25MHZ,
   input  logic                            reset_from_key,
   output logic                            lfsr_tick,
   output logic [dds_lab_pkg::LFSR_W-1:0]  lfsr_state
);

   localparam int CNT_W = (TICK_DIVIDE > 1) ? $clog2(TICK_DIVIDE) : 1;
   localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(TICK_DIVIDE - 1);

   logic [CNT_W-1:0]               tick_cnt;
   logic [dds_lab_pkg::LFSR_W-1:0] lfsr_next;

   // x^5 + x^3 + 1, shifts left
   assign lfsr_next = {lfsr_state[3:0], lfsr_state[4] ^ lfsr_state[2]};

   ////////////////////
   // tick divider
   ////////////////////
   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         tick_cnt   <= '0;
         lfsr_tick  <= 1'b0;
         lfsr_state <= 5'b00001;   // any nonzero seed
      end
      else if (tick_cnt == CNT_LAST)
      begin
         tick_cnt   <= '0;
         lfsr_tick  <= 1'b1;
         lfsr_state <= lfsr_next;   // new value shows with the pulse
      end
      else
      begin
         tick_cnt  <= tick_cnt + 1'b1;
         lfsr_tick <= 1'b0;
      end
   end

   // lock-up state would freeze the modulation
   a_lfsr_nonzero: assert property (@(posedge CLK_25MHZ) disable iff (reset_from_key)
      lfsr_tick |-> (lfsr_state != '0) && (lfsr_state != $past(lfsr_state)));

endmodule

//--- src/scope_sampler.sv
`timescale 1ns/1ps

module scope_sampler #(
   parameter int SAMPLE_DIVIDE = 70_000
) (
   input  logic                                    CLK_25MHZ,
   input  logic                                    reset_from_key,
   input  logic signed [dds_lab_pkg::SAMPLE_W-1:0] mod_sample,
   output logic                                    graph_valid,
   output logic [dds_lab_pkg::GRAPH_W-1:0]         graph_data
);

   localparam int CNT_W = (SAMPLE_DIVIDE > 1) ? $clog2(SAMPLE_DIVIDE) : 1;
   localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(SAMPLE_DIVIDE - 1);
   localparam int SW = dds_lab_pkg::SAMPLE_W;
   localparam int GW = dds_lab_pkg::GRAPH_W;

   logic [CNT_W-1:0] sample_cnt;

   ////////////////////
   // decimation
   ////////////////////
   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
         sample_cnt <= '0;
      else if (sample_cnt == CNT_LAST)
         sample_cnt <= '0;
      else
         sample_cnt <= sample_cnt + 1'b1;
   end

   assign graph_valid = (sample_cnt == CNT_LAST);   // trace takes this cycle's value

   // sign flip turns two's complement into an unsigned trace level
   assign graph_data = {~mod_sample[SW-1], mod_sample[SW-2 -: GW-1]};

endmodule

//--- test/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
   parameter real HALF_PERIOD = 20.0   // 40 ns period
) (
   output logic CLK_25MHZ
);

   initial
   begin
      CLK_25MHZ = 1'b0;
      forever
         #(HALF_PERIOD) CLK_25MHZ = ~CLK_25MHZ;
   end

endmodule

//--- test/tb_dds_lab.sv
`timescale 1ns/1ps

module tb_dds_lab;

   localparam int RESET_CYCLES = 5;
   localparam int DWELL        = 64;   // four LFSR ticks per event
   localparam int N_SCRIPT     = 22;
   localparam int N_RANDOM     = 64;
   localparam int CYCLE_LIMIT  = 2 * (RESET_CYCLES + (N_SCRIPT + N_RANDOM) * (DWELL + 2));
   localparam int TICK_DIV     = 16;
   localparam int SAMPLE_DIV   = 8;
   localparam logic [31:0] BASE_INC  = 32'h0040_0000;
   localparam logic [31:0] FREQ_STEP = 32'h0010_0000;
   localparam logic [31:0] SEED      = 32'hfa8865f0;

   // saw first, arrows up then down to the floor, then each modulation and waveform
   localparam logic [7:0] SCRIPT [0:N_SCRIPT-1] = '{
      8'h03, 8'h83, 8'h48, 8'hc8, 8'h48, 8'hc8, 8'h50, 8'h50, 8'h50, 8'h50,
      8'h50, 8'h50, 8'hd0, 8'h08, 8'h07, 8'h09, 8'h06, 8'h02, 8'h05, 8'h04,
      8'h1c, 8'h84
   };
   localparam logic [7:0] KNOWN [0:19] = '{
      8'h02, 8'h03, 8'h04, 8'h05, 8'h06, 8'h07, 8'h08, 8'h09, 8'h48, 8'h50,
      8'h82, 8'h83, 8'h84, 8'h85, 8'h86, 8'h87, 8'h88, 8'h89, 8'hc8, 8'hd0
   };

   logic                     CLK_25MHZ;
   logic                     reset_from_key;
   logic                     key_event_ready;
   dds_lab_pkg::scan_event_e key_event_type;
   logic [9:0]               held_keys;
   dds_lab_pkg::waveform_e   wave_sel;
   dds_lab_pkg::modulation_e mod_sel;
   logic [31:0]              freq_inc;
   logic [4:0]               lfsr_state;
   logic                     lfsr_tick;
   logic signed [11:0]       signal_sample;
   logic signed [11:0]       mod_sample;
   logic                     graph_valid;
   logic [7:0]               graph_data;

   // reference model state
   logic [9:0]         exp_held;
   logic [1:0]         exp_wave;
   logic [1:0]         exp_mod;
   logic [31:0]        exp_freq;
   logic [4:0]         exp_lfsr;
   logic               exp_tick;
   logic [3:0]         tick_phase;
   int                 tick_total;
   logic [2:0]         scope_phase;
   logic [31:0]        exp_step;   // phase increment incl. FSK
   logic [1:0]         wave_d1;
   logic [1:0]         wave_d2;
   logic [1:0]         mod_d1;
   logic               bit_d1;
   logic [4:0]         lfsr_d1;
   logic [31:0]        step_d1;
   logic [31:0]        step_d2;
   logic signed [11:0] sample_d1;
   logic signed [11:0] exp_mod_sample;
   logic [1:0]         warm;
   logic               hist_ok;
   int                 ev_slot;
   int                 cycle_count = 0;
   logic [31:0]        rng;

   tb_clock_gen clock_gen_inst (
      .CLK_25MHZ (CLK_25MHZ)
   );

   dds_lab_top #(
      .TICK_DIVIDE     (TICK_DIV),
      .SAMPLE_DIVIDE   (SAMPLE_DIV),
      .BASE_INC        (BASE_INC),
      .FREQ_STEP       (FREQ_STEP)
   ) dds_lab_top_inst (
      .CLK_25MHZ       (CLK_25MHZ),
      .reset_from_key  (reset_from_key),
      .key_event_ready (key_event_ready),
      .key_event_type  (key_event_type),
      .held_keys       (held_keys),
      .wave_sel        (wave_sel),
      .mod_sel         (mod_sel),
      .freq_inc        (freq_inc),
      .lfsr_state      (lfsr_state),
      .lfsr_tick       (lfsr_tick),
      .signal_sample   (signal_sample),
      .mod_sample      (mod_sample),
      .graph_valid     (graph_valid),
      .graph_data      (graph_data)
   );

   ////////////////////
   // helpers
   ////////////////////
   function automatic logic [31:0] xorshift32(logic [31:0] state);
      logic [31:0] x;
      x = state;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   // held-key slot of an event, -1 when the key is not one of ours
   function automatic int key_slot(logic [7:0] code);
      logic [7:0] low;
      low = {1'b0, code[6:0]};
      if (low >= 8'h02 && low <= 8'h09)
         return int'(low) - 2;
      if (low == 8'h48)
         return 8;
      if (low == 8'h50)
         return 9;
      return -1;
   endfunction

   function automatic logic [31:0] step_up(logic [31:0] inc);
      logic [32:0] sum;
      sum = {1'b0, inc} + {1'b0, FREQ_STEP};
      if (sum[32])
         return 32'hffff_ffff;   // no wrap
      return sum[31:0];
   endfunction

   function automatic logic [31:0] step_down(logic [31:0] inc);
      if ({1'b0, inc} <= {FREQ_STEP, 1'b0})
         return FREQ_STEP;
      return inc - FREQ_STEP;
   endfunction

   task automatic stop_with_fail();
      $display("RESULT: FAIL");
      $fatal(1, "simulation stopped on the first error");
   endtask

   task automatic report_mismatch(string test, logic [31:0] expected, logic [31:0] actual);
      $display("MISMATCH %s expected %0h actual %0h", test, expected, actual);
      stop_with_fail();
   endtask

   task automatic report_failure(string why);
      $display("ERROR: %s", why);
      stop_with_fail();
   endtask

   task automatic send_event(logic [7:0] code);
      @(posedge CLK_25MHZ);
      #2;
      key_event_ready = 1'b1;
      key_event_type  = dds_lab_pkg::scan_event_e'(code);
      @(posedge CLK_25MHZ);
      #2;
      key_event_ready = 1'b0;
      repeat (DWELL) @(posedge CLK_25MHZ);
   endtask

   ////////////////////
   // reference model
   ////////////////////
   assign ev_slot  = key_slot(key_event_type);
   assign exp_step = (exp_mod == dds_lab_pkg::MOD_FSK && exp_lfsr[0]) ? (exp_freq << 1)
                                                                       : exp_freq;
   assign hist_ok  = (warm == 2'd3);

   always @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         exp_held    <= '0;
         exp_wave    <= dds_lab_pkg::WAVE_SQUARE;
         exp_mod     <= dds_lab_pkg::MOD_NONE;
         exp_freq    <= BASE_INC;
         exp_lfsr    <= 5'b00001;
         exp_tick    <= 1'b0;
         tick_phase  <= '0;
         tick_total  <= 0;
         scope_phase <= '0;
         warm        <= '0;
      end
      else
      begin
         if (key_event_ready && ev_slot >= 0)
         begin
            exp_held[ev_slot] <= ~key_event_type[7];   // break clears
            if (!key_event_type[7])
            begin
               if (ev_slot < 4)
                  exp_wave <= 2'(ev_slot);
               else if (ev_slot < 8)
                  exp_mod <= 2'(ev_slot - 4);
               else if (ev_slot == 8)
                  exp_freq <= step_up(exp_freq);
               else
                  exp_freq <= step_down(exp_freq);
            end
         end
         exp_tick    <= (tick_phase == 4'(TICK_DIV - 1));
         tick_phase  <= tick_phase + 4'd1;   // wraps every 16 cycles
         scope_phase <= scope_phase + 3'd1;
         if (tick_phase == 4'(TICK_DIV - 1))
         begin
            exp_lfsr   <= {exp_lfsr[3:0], exp_lfsr[4] ^ exp_lfsr[2]};
            tick_total <= tick_total + 1;
         end
         if (warm != 2'd3)
            warm <= warm + 2'd1;
      end
      wave_d1   <= exp_wave;
      wave_d2   <= wave_d1;
      mod_d1    <= exp_mod;
      bit_d1    <= exp_lfsr[0];
      lfsr_d1   <= exp_lfsr;
      step_d1   <= exp_step;
      step_d2   <= step_d1;
      sample_d1 <= signal_sample;
   end

   always_comb
   begin
      case (mod_d1)
         dds_lab_pkg::MOD_ASK:
            exp_mod_sample = bit_d1 ? sample_d1 : 12'sd0;
         dds_lab_pkg::MOD_BPSK:
            exp_mod_sample = bit_d1 ? -sample_d1 : sample_d1;
         default:
            exp_mod_sample = sample_d1;
      endcase
   end

   ////////////////////
   // checks
   ////////////////////
   a_held: assert property (@(posedge CLK_25MHZ) disable iff (reset_from_key)
      held_keys == exp_held)
      else report_mismatch("key_hold", 32'(exp_held), 32'(held_keys));
   a_wave: assert property (@(posedge CLK_25MHZ) disable iff (reset_from_key)
      wave_sel == exp_wave)
      else report_mismatch("wave_select", 32'(exp_wave), 32'(wave_sel));
   a_mod: assert property (@(posedge CLK_25MHZ) disable iff (reset_from_key)
      mod_sel == exp_mod)
      else report_mismatch("mod_select", 32'(exp_mod), 32'(mod_sel));
   a_freq: assert property (@(posedge CLK_25MHZ) disable iff (reset_from_key)
      freq_inc == exp_freq)
      else report_mismatch("freq_step", exp_freq, freq_inc);
   a_saw_step: assert property (@(posedge CLK_25MHZ) disable iff (reset_from_key)
      (hist_ok && wave_d1 == dds_lab_pkg::WAVE_SAW && wave_d2 == dds_lab_pkg::WAVE_SAW)
      |-> (12'(signal_sample - sample_d1) == step_d2[31:20]))
      else report_mismatch("saw_step", 32'(step_d2[31:20]), 32'(12'(signal_sample - sample_d1)));
   a_tick: assert property (@(posedge CLK_25MHZ) disable iff (reset_from_key)
      lfsr_tick == exp_tick)
      else report_mismatch("lfsr_tick", 32'(exp_tick), 32'(lfsr_tick));
   a_lfsr: assert property (@(posedge CLK_25MHZ) disable iff (reset_from_key)
      lfsr_state == exp_lfsr)
      else report_mismatch("lfsr_state", 32'(exp_lfsr), 32'(lfsr_state));
   a_lfsr_zero: assert property (@(posedge CLK_25MHZ) disable iff (reset_from_key)
      lfsr_state != 5'd0)
      else report_failure("the LFSR reached the all-zero state");
   a_lfsr_period: assert property (@(posedge CLK_25MHZ) disable iff (reset_from_key)
      lfsr_tick |-> ((lfsr_state == 5'b00001) == (tick_total % 31 == 0)))
      else report_failure("the LFSR sequence does not repeat after exactly 31 ticks");
   a_square: assert property (@(posedge CLK_25MHZ) disable iff (reset_from_key)
      (hist_ok && wave_d1 == dds_lab_pkg::WAVE_SQUARE)
      |-> (signal_sample == 12'sd2047 || signal_sample == -12'sd2047))
      else report_failure("the square wave left the +2047/-2047 levels");
   a_noise: assert property (@(posedge CLK_25MHZ) disable iff (reset_from_key)
      (hist_ok && wave_d1 == dds_lab_pkg::WAVE_NOISE) |-> (signal_sample == {lfsr_d1, 7'd0}))
      else report_mismatch("noise", 32'({lfsr_d1, 7'd0}), 32'(signal_sample));
   a_mod_sample: assert property (@(posedge CLK_25MHZ) disable iff (reset_from_key)
      hist_ok |-> (mod_sample == exp_mod_sample))
      else report_mismatch("modulation", 32'(exp_mod_sample), 32'(mod_sample));
   a_graph_valid: assert property (@(posedge CLK_25MHZ) disable iff (reset_from_key)
      graph_valid == (scope_phase == 3'(SAMPLE_DIV - 1)))
      else report_mismatch("scope_valid", 32'(scope_phase == 3'(SAMPLE_DIV - 1)),
                           32'(graph_valid));
   a_graph_data: assert property (@(posedge CLK_25MHZ) disable iff (reset_from_key)
      graph_valid |-> (graph_data == (mod_sample[11:4] ^ 8'h80)))
      else report_mismatch("scope_data", 32'(mod_sample[11:4] ^ 8'h80), 32'(graph_data));

   ////////////////////
   // timeout
   ////////////////////
   always @(posedge CLK_25MHZ)
   begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= CYCLE_LIMIT)
      begin
         $display("ERROR: the run exceeded its cycle limit of %0d cycles", CYCLE_LIMIT);
         stop_with_fail();
      end
   end

   ////////////////////
   // stimulus
   ////////////////////
   initial
   begin
      reset_from_key  = 1'b1;
      key_event_ready = 1'b0;
      key_event_type  = dds_lab_pkg::SC_MAKE_1;
      rng             = SEED;
      repeat (RESET_CYCLES) @(posedge CLK_25MHZ);
      #2;
      reset_from_key = 1'b0;
      for (int i = 0; i < N_SCRIPT; i++)
         send_event(SCRIPT[i]);
      for (int i = 0; i < N_RANDOM; i++)
      begin
         rng = xorshift32(rng);
         send_event(KNOWN[int'(rng % 32'd20)]);   // any known make or break
      end
      $display("RESULT: PASS");
      $finish;
   end

endmodule
